/* lsu_params.svh */
// --------------------
// Build-time settings of the load/store unit
// The store buffer depth must be at least 2
// The privileged region is one inclusive range of byte addresses
// --------------------

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Number of pending stores the buffer can hold
`define LSU_SB_DEPTH 4

// First byte address of the privileged region
`define LSU_PRIV_START 32'h0000_0C00

// Last byte address of the privileged region, inclusive
`define LSU_PRIV_END 32'h0000_0FFF

`endif

/* lsu_pkg.sv */
// --------------------
// Shared types of the load/store unit
// All addresses are byte addresses, memory words are 32 bits
// --------------------

`default_nettype none

package lsu_pkg;

    typedef logic [31:0] data_word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_sel_t;

    // Access size, shared by loads and stores
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } lsu_width_t;

    typedef struct packed {
        addr_t      address;
        lsu_width_t width;
        logic       signed_load;
    } load_req_t;

    typedef struct packed {
        addr_t      address;
        data_word_t data;
        lsu_width_t width;
    } store_req_t;

    typedef struct packed {
        data_word_t data;
        logic       misaligned;
        logic       illegal;
    } load_rsp_t;

    // Word-aligned request towards the bus port, data lanes already placed
    typedef struct packed {
        addr_t      address;
        logic       we;
        data_word_t data;
        byte_sel_t  sel;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_BUFFER,
        WAIT_MEMORY,
        RESPOND
    } load_state_t;

endpackage

`default_nettype wire

/* store_buffer.sv */
// --------------------
// Circular FIFO of stores waiting to be written to memory
// Stores are assumed aligned and legal, no checks are made here
// Lookup and drain requests are combinational from the entries
// --------------------

`default_nettype none

`include "lsu_params.svh"

module store_buffer (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      store_valid_i,
    input  wire lsu_pkg::store_req_t store_req_i,
    output logic                     store_ready_o,
    input  wire lsu_pkg::addr_t      lookup_addr_i,
    output logic                     fwd_hit_o,
    output lsu_pkg::data_word_t      fwd_data_o,
    output logic                     conflict_o,
    output logic                     empty_o,
    output logic                     mem_req_valid_o,
    output lsu_pkg::mem_req_t        mem_req_o,
    input  wire                      mem_ack_i
);

    import lsu_pkg::*;

    localparam int DEPTH = `LSU_SB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_req_t         entry_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    mem_req_t         new_entry;
    logic             push;
    logic             pop;
    logic             any_match;
    byte_sel_t        match_sel;

    // Advance a pointer, wrapping at the last entry so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // --------------------
    // Store formatting
    // --------------------

    // Replicate the data over all lanes, the byte select picks the ones written
    always_comb begin
        new_entry.address = {store_req_i.address[31:2], 2'b00};
        new_entry.we      = 1'b1;
        case (store_req_i.width)
            BYTE: begin
                new_entry.data = {4{store_req_i.data[7:0]}};
                new_entry.sel  = 4'b0001 << store_req_i.address[1:0];
            end
            HALF: begin
                new_entry.data = {2{store_req_i.data[15:0]}};
                new_entry.sel  = 4'b0011 << {store_req_i.address[1], 1'b0};
            end
            default: begin
                new_entry.data = store_req_i.data;
                new_entry.sel  = 4'b1111;
            end
        endcase
    end

    // --------------------
    // FIFO control
    // --------------------

    assign store_ready_o = count_q != CNT_W'(DEPTH);
    assign empty_o       = count_q == '0;
    assign push          = store_valid_i && store_ready_o;
    assign pop           = mem_ack_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            entry_q[wr_ptr_q] <= new_entry;
        end
    end

    // The oldest entry is offered to the bus port until it is acknowledged
    assign mem_req_valid_o = !empty_o;
    assign mem_req_o       = entry_q[rd_ptr_q];

    // --------------------
    // Forwarding lookup
    // --------------------

    // Walk from oldest to youngest so the last match kept is the youngest one
    always_comb begin : lookup
        int idx;
        any_match  = 1'b0;
        match_sel  = '0;
        fwd_data_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = (int'(rd_ptr_q) + i) % DEPTH;
            if (i < int'(count_q) && entry_q[idx].address[31:2] == lookup_addr_i[31:2]) begin
                any_match  = 1'b1;
                match_sel  = entry_q[idx].sel;
                fwd_data_o = entry_q[idx].data;
            end
        end
    end

    // Only a full-word store can supply every byte of the load
    assign fwd_hit_o  = any_match && (match_sel == 4'b1111);
    assign conflict_o = any_match && !fwd_hit_o;

endmodule

`default_nettype wire

/* load_unit.sv */
// --------------------
// Load request FSM with alignment, privilege and forwarding handling
// One load is in flight at a time, load_ready_o is high only in IDLE
// Exceptions and forwarding hits answer one cycle after acceptance
// Privileged region loads always wait for an empty store buffer
// --------------------

`default_nettype none

`include "lsu_params.svh"

module load_unit (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      load_valid_i,
    input  wire lsu_pkg::load_req_t  load_req_i,
    input  wire                      privilege_i,
    output logic                     load_ready_o,
    output lsu_pkg::addr_t           lookup_addr_o,
    input  wire                      fwd_hit_i,
    input  wire lsu_pkg::data_word_t fwd_data_i,
    input  wire                      conflict_i,
    input  wire                      sb_empty_i,
    output logic                     mem_req_valid_o,
    output lsu_pkg::mem_req_t        mem_req_o,
    input  wire                      mem_ack_i,
    input  wire lsu_pkg::data_word_t mem_data_i,
    output logic                     rsp_valid_o,
    output lsu_pkg::load_rsp_t       rsp_o
);

    import lsu_pkg::*;

    load_state_t state_q;
    load_state_t state_d;
    load_req_t   req_q;
    logic        misaligned_q;
    logic        illegal_q;
    logic        priv_region_q;
    data_word_t  word_q;
    logic        misaligned;
    logic        in_priv_region;
    logic        illegal;
    logic        accept;
    data_word_t  shifted;
    data_word_t  sliced;

    // --------------------
    // Request checks
    // --------------------

    // Halves need a 2 byte boundary and words a 4 byte boundary
    always_comb begin
        case (load_req_i.width)
            HALF:    misaligned = load_req_i.address[0];
            WORD:    misaligned = load_req_i.address[1:0] != 2'b00;
            default: misaligned = 1'b0;
        endcase
    end

    assign in_priv_region = (load_req_i.address >= `LSU_PRIV_START) &&
                            (load_req_i.address <= `LSU_PRIV_END);
    assign illegal        = in_priv_region && !privilege_i;

    assign load_ready_o = state_q == IDLE;
    assign accept       = load_valid_i && load_ready_o;

    // In IDLE the incoming address is looked up so a hit can answer next cycle
    assign lookup_addr_o = (state_q == IDLE) ? load_req_i.address : req_q.address;

    // --------------------
    // FSM
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (misaligned || illegal) begin
                        state_d = RESPOND;
                    end else if (in_priv_region) begin
                        // Forwarding is skipped, memory must see every older store
                        state_d = WAIT_BUFFER;
                    end else if (fwd_hit_i) begin
                        state_d = RESPOND;
                    end else if (conflict_i) begin
                        state_d = WAIT_BUFFER;
                    end else begin
                        state_d = WAIT_MEMORY;
                    end
                end
            end
            WAIT_BUFFER: begin
                // Partial stores to the same word have to reach memory first
                if (priv_region_q ? sb_empty_i : !conflict_i) begin
                    state_d = WAIT_MEMORY;
                end
            end
            WAIT_MEMORY: begin
                if (mem_ack_i) begin
                    state_d = RESPOND;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Forwarded data is captured on every acceptance and replaced by a memory read
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q         <= load_req_i;
            misaligned_q  <= misaligned;
            illegal_q     <= illegal;
            priv_region_q <= in_priv_region;
            word_q        <= fwd_data_i;
        end else if (state_q == WAIT_MEMORY && mem_ack_i) begin
            word_q <= mem_data_i;
        end
    end

    // --------------------
    // Memory read and response
    // --------------------

    always_comb begin
        mem_req_o.address = {req_q.address[31:2], 2'b00};
        mem_req_o.we      = 1'b0;
        mem_req_o.data    = '0;
        mem_req_o.sel     = 4'b1111;
    end

    assign mem_req_valid_o = state_q == WAIT_MEMORY;

    // Bring the addressed byte or half down to bit 0, then extend it
    always_comb begin
        shifted = word_q >> {req_q.address[1:0], 3'b000};
        case (req_q.width)
            BYTE: sliced = req_q.signed_load ? {{24{shifted[7]}}, shifted[7:0]}
                                             : {24'b0, shifted[7:0]};
            HALF: sliced = req_q.signed_load ? {{16{shifted[15]}}, shifted[15:0]}
                                             : {16'b0, shifted[15:0]};
            default: sliced = word_q;
        endcase
        rsp_o.data       = (misaligned_q || illegal_q) ? '0 : sliced;
        rsp_o.misaligned = misaligned_q;
        rsp_o.illegal    = illegal_q;
    end

    assign rsp_valid_o = state_q == RESPOND;

endmodule

`default_nettype wire

/* wb_port.sv */
// --------------------
// Wishbone classic master shared by loads and store drains
// One cycle is open at a time and is never preempted
// Bus errors and retries are not supported
// --------------------

`default_nettype none

module wb_port (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      ld_req_valid_i,
    input  wire lsu_pkg::mem_req_t   ld_req_i,
    output logic                     ld_ack_o,
    output lsu_pkg::data_word_t      ld_data_o,
    input  wire                      sb_req_valid_i,
    input  wire lsu_pkg::mem_req_t   sb_req_i,
    output logic                     sb_ack_o,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output lsu_pkg::addr_t           wb_adr_o,
    output lsu_pkg::data_word_t      wb_dat_o,
    output lsu_pkg::byte_sel_t       wb_sel_o,
    input  wire lsu_pkg::data_word_t wb_dat_i,
    input  wire                      wb_ack_i
);

    import lsu_pkg::*;

    logic     cyc_q;
    logic     owner_ld_q;
    mem_req_t req_q;

    // A waiting load wins over a drain when the bus is free
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cyc_q      <= 1'b0;
            owner_ld_q <= 1'b0;
        end else if (!cyc_q) begin
            if (ld_req_valid_i) begin
                cyc_q      <= 1'b1;
                owner_ld_q <= 1'b1;
            end else if (sb_req_valid_i) begin
                cyc_q      <= 1'b1;
                owner_ld_q <= 1'b0;
            end
        end else if (wb_ack_i) begin
            cyc_q <= 1'b0;
        end
    end

    // Latched once per cycle so the bus stays stable until the acknowledge
    always_ff @(posedge clk_i) begin
        if (!cyc_q) begin
            req_q <= ld_req_valid_i ? ld_req_i : sb_req_i;
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_we_o  = req_q.we;
    assign wb_adr_o = req_q.address;
    assign wb_dat_o = req_q.data;
    assign wb_sel_o = req_q.sel;

    // The acknowledge goes back only to the side that owns the open cycle
    assign ld_ack_o  = cyc_q && wb_ack_i && owner_ld_q;
    assign sb_ack_o  = cyc_q && wb_ack_i && !owner_ld_q;
    assign ld_data_o = wb_dat_i;

endmodule

`default_nettype wire

/* lsu_top.sv */
// --------------------
// Load/store unit top level
// Stores drain in order, loads wait for conflicting stores
// The result is a one-cycle pulse with no back-pressure
// --------------------

`default_nettype none

module lsu_top (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      store_valid_i,
    input  wire lsu_pkg::store_req_t store_req_i,
    output logic                     store_ready_o,
    input  wire                      load_valid_i,
    input  wire lsu_pkg::load_req_t  load_req_i,
    input  wire                      privilege_i,
    output logic                     load_ready_o,
    output logic                     load_rsp_valid_o,
    output lsu_pkg::load_rsp_t       load_rsp_o,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output lsu_pkg::addr_t           wb_adr_o,
    output lsu_pkg::data_word_t      wb_dat_o,
    output lsu_pkg::byte_sel_t       wb_sel_o,
    input  wire lsu_pkg::data_word_t wb_dat_i,
    input  wire                      wb_ack_i
);

    import lsu_pkg::*;

    // Forwarding lookup between load unit and store buffer
    addr_t      lookup_addr;
    logic       fwd_hit;
    data_word_t fwd_data;
    logic       conflict;
    logic       sb_empty;

    // Memory requests towards the bus port
    logic       ld_mem_req;
    mem_req_t   ld_mem_cmd;
    logic       ld_mem_ack;
    data_word_t ld_mem_data;
    logic       sb_mem_req;
    mem_req_t   sb_mem_cmd;
    logic       sb_mem_ack;

    store_buffer store_buffer_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .store_valid_i   (store_valid_i),
        .store_req_i     (store_req_i),
        .store_ready_o   (store_ready_o),
        .lookup_addr_i   (lookup_addr),
        .fwd_hit_o       (fwd_hit),
        .fwd_data_o      (fwd_data),
        .conflict_o      (conflict),
        .empty_o         (sb_empty),
        .mem_req_valid_o (sb_mem_req),
        .mem_req_o       (sb_mem_cmd),
        .mem_ack_i       (sb_mem_ack)
    );

    load_unit load_unit_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .load_valid_i    (load_valid_i),
        .load_req_i      (load_req_i),
        .privilege_i     (privilege_i),
        .load_ready_o    (load_ready_o),
        .lookup_addr_o   (lookup_addr),
        .fwd_hit_i       (fwd_hit),
        .fwd_data_i      (fwd_data),
        .conflict_i      (conflict),
        .sb_empty_i      (sb_empty),
        .mem_req_valid_o (ld_mem_req),
        .mem_req_o       (ld_mem_cmd),
        .mem_ack_i       (ld_mem_ack),
        .mem_data_i      (ld_mem_data),
        .rsp_valid_o     (load_rsp_valid_o),
        .rsp_o           (load_rsp_o)
    );

    wb_port wb_port_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ld_req_valid_i (ld_mem_req),
        .ld_req_i       (ld_mem_cmd),
        .ld_ack_o       (ld_mem_ack),
        .ld_data_o      (ld_mem_data),
        .sb_req_valid_i (sb_mem_req),
        .sb_req_i       (sb_mem_cmd),
        .sb_ack_o       (sb_mem_ack),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_o       (wb_dat_o),
        .wb_sel_o       (wb_sel_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i)
    );

endmodule

`default_nettype wire

/* lsu_checker.sv */
// --------------------
// Protocol assertions for the load/store unit top level
// Bound to lsu_top, counts its failed assertions in fail_count
// --------------------

`default_nettype none

module lsu_checker (
    input wire                      clk_i,
    input wire                      rst_n_i,
    input wire                      load_ready_o,
    input wire                      load_rsp_valid_o,
    input wire                      wb_cyc_o,
    input wire                      wb_stb_o,
    input wire                      wb_ack_i,
    input wire lsu_pkg::addr_t      wb_adr_o,
    input wire lsu_pkg::data_word_t wb_dat_o,
    input wire lsu_pkg::byte_sel_t  wb_sel_o
);

    int fail_count = 0;

    // A strobe outside an open cycle is not a valid transfer
    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o |-> wb_cyc_o)
        else begin
            fail_count++;
            $error("wb_stb_o high while wb_cyc_o is low");
        end

    // The slave may sample the request in any cycle until it acknowledges
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_stb_o && !wb_ack_i) |=>
            ($stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_sel_o)))
        else begin
            fail_count++;
            $error("Wishbone request changed before the acknowledge");
        end

    a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_rsp_valid_o |=> !load_rsp_valid_o)
        else begin
            fail_count++;
            $error("load_rsp_valid_o stayed high for two cycles");
        end

    // The FSM leaves reset in IDLE
    a_ready_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> load_ready_o)
        else begin
            fail_count++;
            $error("load_ready_o low right after reset");
        end

endmodule

`default_nettype wire

/* lsu_tb.sv */
// --------------------
// Testbench of lsu_top with a Wishbone memory model of 4 KiB
// All test addresses stay below 32'h1000, wait states come from the LFSR
// One load is in flight at a time so the shadow memory gives its value
// --------------------

`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

    import lsu_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int LIMIT     = 2000;

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    logic       store_valid_i;
    store_req_t store_req_i;
    logic       store_ready_o;
    logic       load_valid_i;
    load_req_t  load_req_i;
    logic       privilege_i;
    logic       load_ready_o;
    logic       load_rsp_valid_o;
    load_rsp_t  load_rsp_o;
    logic       wb_cyc_o;
    logic       wb_stb_o;
    logic       wb_we_o;
    addr_t      wb_adr_o;
    data_word_t wb_dat_o;
    byte_sel_t  wb_sel_o;
    data_word_t wb_dat_i;
    logic       wb_ack_i;

    data_word_t mem_model [MEM_WORDS];
    data_word_t shadow [MEM_WORDS];
    logic [31:0] lfsr_state = 32'haec5_5dbe;
    int          cycle_q = 0;
    int          errors = 0;
    int          checks = 0;
    int          write_count = 0;
    int          cyc_high_count = 0;
    int          last_read_writes = 0;
    load_rsp_t   exp_q [$];
    logic        fast_q [$];
    int          accept_q [$];

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) cycle_q <= cycle_q + 1;

    lsu_top lsu_top_inst (.*);

    bind lsu_top lsu_checker lsu_checker_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .load_ready_o     (load_ready_o),
        .load_rsp_valid_o (load_rsp_valid_o),
        .wb_cyc_o         (wb_cyc_o),
        .wb_stb_o         (wb_stb_o),
        .wb_ack_i         (wb_ack_i),
        .wb_adr_o         (wb_adr_o),
        .wb_dat_o         (wb_dat_o),
        .wb_sel_o         (wb_sel_o)
    );

    // --------------------
    // Random numbers and reference model
    // --------------------

    // Galois LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b           = lfsr_state[0];
            lfsr_state  = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // Expected load result from the word as software sees it
    function automatic load_rsp_t expect_load(input data_word_t word, input load_req_t req,
                                              input logic priv);
        load_rsp_t  rsp;
        logic [7:0] b;
        logic [15:0] h;
        rsp = '0;
        if (req.width == HALF) begin
            rsp.misaligned = req.address[0];
        end else if (req.width == WORD) begin
            rsp.misaligned = req.address[1:0] != 2'b00;
        end
        rsp.illegal = !priv && req.address >= `LSU_PRIV_START && req.address <= `LSU_PRIV_END;
        if (rsp.misaligned || rsp.illegal) begin
            return rsp;
        end
        b = word[req.address[1:0]*8 +: 8];
        h = word[req.address[1]*16 +: 16];
        case (req.width)
            BYTE:    rsp.data = req.signed_load ? {{24{b[7]}}, b} : {24'h0, b};
            HALF:    rsp.data = req.signed_load ? {{16{h[15]}}, h} : {16'h0, h};
            default: rsp.data = word;
        endcase
        return rsp;
    endfunction

    // Memory as it must look once every accepted store has landed
    function automatic void apply_store(input store_req_t req);
        int idx;
        idx = req.address[11:2];
        case (req.width)
            BYTE:    shadow[idx][req.address[1:0]*8 +: 8] = req.data[7:0];
            HALF:    shadow[idx][req.address[1]*16 +: 16] = req.data[15:0];
            default: shadow[idx] = req.data;
        endcase
    endfunction

    // --------------------
    // Checks and failure reporting
    // --------------------

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rsp(input load_rsp_t got, input load_rsp_t exp);
        check_word("load_rsp_o.data", got.data, exp.data);
        check_word("load_rsp_o.misaligned", 32'(got.misaligned), 32'(exp.misaligned));
        check_word("load_rsp_o.illegal", 32'(got.illegal), 32'(exp.illegal));
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Regression failed");
        $finish;
    endtask

    // --------------------
    // Wishbone memory model
    // --------------------

    // Acts a little after each edge on the bus state that the edge produced
    always @(posedge clk_i) begin : wb_memory
        int wait_left;
        int idx;
        #1;
        if (wb_cyc_o) begin
            cyc_high_count++;
        end
        if (wb_ack_i) begin
            wb_ack_i = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_left < 0) begin
                wait_left = rand_bits(2);
            end
            if (wait_left == 0) begin
                idx = wb_adr_o[11:2];
                if (wb_we_o) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_sel_o[i]) begin
                            mem_model[idx][i*8 +: 8] = wb_dat_o[i*8 +: 8];
                        end
                    end
                    write_count++;
                end else begin
                    wb_dat_i         = mem_model[idx];
                    last_read_writes = write_count;
                end
                wb_ack_i  = 1'b1;
                wait_left = -1;
            end else begin
                wait_left--;
            end
        end else begin
            wait_left = -1;
        end
    end

    // --------------------
    // Response comparer
    // --------------------

    always @(posedge clk_i) begin : compare
        load_rsp_t exp;
        logic      fast;
        int        acc;
        if (rst_n_i && load_rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A load response arrived with no load in flight");
            end else begin
                exp  = exp_q.pop_front();
                fast = fast_q.pop_front();
                acc  = accept_q.pop_front();
                check_rsp(load_rsp_o, exp);
                if (fast && cycle_q - acc != 1) begin
                    errors++;
                    $display("Response took %0d cycles where one was expected", cycle_q - acc);
                end
            end
        end
    end

    // --------------------
    // Stimulus tasks
    // --------------------

    task automatic drive_store(input addr_t addr, input data_word_t data, input lsu_width_t w);
        int n;
        store_valid_i       = 1'b1;
        store_req_i.address = addr;
        store_req_i.data    = data;
        store_req_i.width   = w;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n == LIMIT) begin
                timeout_fail("store_ready_o");
            end
        end while (!store_ready_o);
        apply_store(store_req_i);
        #1 store_valid_i = 1'b0;
    endtask

    // Issues one load and waits for its response, fast asks for a one-cycle answer
    task automatic drive_load(input addr_t addr, input lsu_width_t w, input logic sgn,
                              input logic priv, input logic fast);
        int        n;
        load_rsp_t exp;
        load_valid_i           = 1'b1;
        load_req_i.address     = addr;
        load_req_i.width       = w;
        load_req_i.signed_load = sgn;
        privilege_i            = priv;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n == LIMIT) begin
                timeout_fail("load_ready_o");
            end
        end while (!load_ready_o);
        exp = expect_load(shadow[addr[11:2]], load_req_i, priv);
        exp_q.push_back(exp);
        fast_q.push_back(fast || exp.misaligned || exp.illegal);
        accept_q.push_back(cycle_q);
        #1 load_valid_i = 1'b0;
        n = 0;
        // The comparer pops at the edge, so look only once that edge has settled
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n == LIMIT) begin
                timeout_fail("load_rsp_valid_o");
            end
        end
    endtask

    // A privileged load to the privileged region waits for an empty buffer
    task automatic drain_stores();
        drive_load(`LSU_PRIV_START, WORD, 1'b0, 1'b1, 1'b0);
    endtask

    // --------------------
    // Tests
    // --------------------

    initial begin : main
        int         cyc_before;
        int         writes_before;
        logic [1:0] w;
        addr_t      a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = (i + 1) * 32'h9e37_79b9 ^ {i[15:0], ~i[15:0]};
            shadow[i]    = mem_model[i];
        end
        rst_n_i       = 1'b0;
        store_valid_i = 1'b0;
        store_req_i   = '0;
        load_valid_i  = 1'b0;
        load_req_i    = '0;
        privilege_i   = 1'b0;
        wb_dat_i      = '0;
        wb_ack_i      = 1'b0;
        repeat (5) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        // Every width, sign and legal offset
        for (int k = 0; k < 4; k++) begin
            for (int o = 0; o < 4; o++) begin
                for (int s = 0; s < 2; s++) begin
                    a = 32'h40 + k * 4 + o;
                    drive_load(a, BYTE, s[0], 1'b0, 1'b0);
                    if (o[0] == 1'b0) begin
                        drive_load(a, HALF, s[0], 1'b0, 1'b0);
                    end
                    if (o == 0) begin
                        drive_load(a, WORD, s[0], 1'b0, 1'b0);
                    end
                end
            end
        end

        // Exceptions answer in one cycle and never touch the bus
        cyc_before = cyc_high_count;
        drive_load(32'h51, HALF, 1'b1, 1'b0, 1'b1);
        drive_load(32'h53, HALF, 1'b0, 1'b0, 1'b1);
        drive_load(32'h52, WORD, 1'b0, 1'b0, 1'b1);
        drive_load(32'h57, WORD, 1'b0, 1'b1, 1'b1);
        drive_load(32'hC04, WORD, 1'b0, 1'b0, 1'b1);
        drive_load(32'hFFF, BYTE, 1'b1, 1'b0, 1'b1);
        if (cyc_high_count != cyc_before) begin
            errors++;
            $display("A Wishbone cycle started for a load with an exception");
        end

        // Forwarding from a full word, then a partial store that must drain
        // The second load may find the word store already drained
        drive_store(32'h80, 32'hdead_beef, WORD);
        drive_load(32'h80, WORD, 1'b0, 1'b0, 1'b1);
        drive_load(32'h82, HALF, 1'b1, 1'b0, 1'b0);
        drive_store(32'h85, 32'h0000_00a5, BYTE);
        drive_load(32'h84, WORD, 1'b0, 1'b0, 1'b0);

        // Privileged load ordered behind all older stores
        // Unrelated stores come last so only an empty buffer lets the read go
        drain_stores();
        writes_before = write_count;
        drive_store(32'hC10, 32'h5566_7788, WORD);
        drive_store(32'hC13, 32'h0000_0099, BYTE);
        drive_store(32'h90, 32'h1111_2222, WORD);
        drive_store(32'h96, 32'h0000_3344, HALF);
        drive_load(32'hC10, WORD, 1'b0, 1'b1, 1'b0);
        if (last_read_writes != writes_before + 4) begin
            errors++;
            $display("Privileged load read memory before the older stores were written");
        end

        // Random mix over a few words so that stores and loads collide
        for (int n = 0; n < 300; n++) begin
            a = (rand_bits(3) == 0) ? 32'hC00 : 32'h100;
            a = a | rand_bits(6);
            w = rand_bits(2);
            if (w == 2'd3) begin
                w = 2'd2;
            end
            if (rand_bits(2) != 0) begin
                if (w == 2'd1) begin
                    a[0] = 1'b0;
                end else if (w == 2'd2) begin
                    a[1:0] = 2'b00;
                end
                drive_store(a, rand_bits(32), lsu_width_t'(w));
            end else begin
                drive_load(a, lsu_width_t'(w), rand_bits(1), rand_bits(1), 1'b0);
            end
        end

        // Memory must match once every store has drained
        drain_stores();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word("memory word", mem_model[i], shadow[i]);
        end

        errors += lsu_top_inst.lsu_checker_inst.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_top.f */
+incdir+.
lsu_pkg.sv
store_buffer.sv
load_unit.sv
wb_port.sv
lsu_top.sv
lsu_checker.sv
lsu_tb.sv

/* run.sh */
#!/bin/sh
# Builds lsu_tb with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb -Mdir obj_dir -f lsu_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vlsu_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
